// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert --timescale 1ns/1ns
TOP       ?= adc_capture_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
+incdir+design
design/adc_capture_pkg.sv
design/adc_lane_if.sv
design/adc_wb_if.sv
design/adc_deserialise.sv
design/adc_retime.sv
design/adc_align.sv
design/adc_csr.sv
design/adc_capture_top.sv
verification/adc_capture_tb.sv

// ==== design/adc_align.sv ====
`timescale 1ns/1ns
`include "adc_capture_defs.svh"

module adc_align (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  adc_capture_pkg::sample_t [`ADC_LANES-1:0]  lane_data,
  input  logic [`ADC_LANES-1:0]                       lane_empty,
  input  logic                                        twos,
  output logic                                        rd_en,
  output adc_capture_pkg::sample_t [`ADC_LANES-1:0]  sample_data,
  output logic                                        sample_vld
);

  adc_capture_pkg::sample_t msb_flip;

  // Offset binary to two's complement is an MSB inversion.
  assign msb_flip = {twos, {(`ADC_BITS-1){1'b0}}};

  // All lanes are popped together.
  assign rd_en = ~|lane_empty;

  always_ff @(posedge clk) begin
    if (rd_en) begin
      for (int i = 0; i < `ADC_LANES; i++) begin
        sample_data[i] <= lane_data[i] ^ msb_flip;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sample_vld <= 1'b0;
    end else begin
      sample_vld <= rd_en;
    end
  end

endmodule

// ==== design/adc_capture_defs.svh ====
`ifndef ADC_CAPTURE_DEFS_SVH
`define ADC_CAPTURE_DEFS_SVH

// Number of ADC lanes.
`define ADC_LANES 4

// Sample width. Two bits arrive per adc_clk0 cycle.
`define ADC_BITS 12

// FIFO address width for 8 words per lane.
`define ADC_FIFO_AW 3

// Wishbone word address and data widths.
`define WB_AW 4
`define WB_DW 32

`endif

// ==== design/adc_capture_pkg.sv ====
`include "adc_capture_defs.svh"

package adc_capture_pkg;

  // One deserialised sample.
  typedef logic [`ADC_BITS-1:0] sample_t;

  // Frame tracking in the deserialiser.
  typedef enum logic {
    SEEK,
    TRACK
  } deser_state_e;

  // Register word addresses.
  typedef enum logic [`WB_AW-1:0] {
    CTRL    = 4'd0,
    STATUS  = 4'd1,
    FC_PAT0 = 4'd2,
    FC_PAT1 = 4'd3,
    FC_PAT2 = 4'd4,
    FC_PAT3 = 4'd5
  } csr_addr_e;

endpackage

// ==== design/adc_capture_top.sv ====
`timescale 1ns/1ns
`include "adc_capture_defs.svh"

module adc_capture_top (
  input  logic                                 adc_clk0,
  input  logic                                 fab_clk,
  input  logic                                 rst_n,
  input  logic [`ADC_LANES-1:0]                rise,
  input  logic [`ADC_LANES-1:0]                fall,
  input  logic [`ADC_LANES-1:0]                fc_rise,
  input  logic [`ADC_LANES-1:0]                fc_fall,
  input  logic                                 wb_cyc,
  input  logic                                 wb_stb,
  input  logic                                 wb_we,
  input  logic [`WB_AW-1:0]                    wb_adr,
  input  logic [`WB_DW-1:0]                    wb_dat_w,
  output logic [`WB_DW-1:0]                    wb_dat_r,
  output logic                                 wb_ack,
  output logic [`ADC_LANES-1:0][`ADC_BITS-1:0] sample_data,
  output logic                                 sample_vld
);

  adc_capture_pkg::sample_t [`ADC_LANES-1:0] word;
  adc_capture_pkg::sample_t [`ADC_LANES-1:0] fifo_dout;
  logic [`ADC_LANES-1:0]                     word_vld;
  logic [`ADC_LANES-1:0]                     frame_err;
  logic [`ADC_LANES-1:0]                     overflow;
  logic [`ADC_LANES-1:0]                     fifo_empty;
  logic [`ADC_LANES-1:0][`ADC_BITS-1:0]      fc_pattern;
  logic                                      rd_en;
  logic                                      twos;

  adc_wb_if wb_if ();

  assign wb_if.cyc   = wb_cyc;
  assign wb_if.stb   = wb_stb;
  assign wb_if.we    = wb_we;
  assign wb_if.adr   = wb_adr;
  assign wb_if.dat_w = wb_dat_w;
  assign wb_dat_r    = wb_if.dat_r;
  assign wb_ack      = wb_if.ack;

  for (genvar i = 0; i < `ADC_LANES; i++) begin : g_lane
    adc_lane_if lane_if ();

    assign lane_if.rise    = rise[i];
    assign lane_if.fall    = fall[i];
    assign lane_if.fc_rise = fc_rise[i];
    assign lane_if.fc_fall = fc_fall[i];

    adc_deserialise deser_i (
      .clk        (adc_clk0),
      .rst_n      (rst_n),
      .lane       (lane_if),
      .word       (word[i]),
      .word_vld   (word_vld[i]),
      .fc_pattern (fc_pattern[i]),
      .frame_err  (frame_err[i])
    );

    adc_retime retime_i (
      .wr_clk   (adc_clk0),
      .rd_clk   (fab_clk),
      .rst_n    (rst_n),
      .din      (word[i]),
      .dvld     (word_vld[i]),
      .rd_en    (rd_en),
      .dout     (fifo_dout[i]),
      .empty    (fifo_empty[i]),
      .overflow (overflow[i])
    );
  end

  adc_align align_i (
    .clk         (fab_clk),
    .rst_n       (rst_n),
    .lane_data   (fifo_dout),
    .lane_empty  (fifo_empty),
    .twos        (twos),
    .rd_en       (rd_en),
    .sample_data (sample_data),
    .sample_vld  (sample_vld)
  );

  adc_csr csr_i (
    .clk        (fab_clk),
    .rst_n      (rst_n),
    .wb         (wb_if),
    .overflow   (overflow),
    .frame_err  (frame_err),
    .fc_pattern (fc_pattern),
    .twos       (twos)
  );

endmodule

// ==== design/adc_csr.sv ====
`timescale 1ns/1ns
`include "adc_capture_defs.svh"

module adc_csr (
  input  logic                                 clk,
  input  logic                                 rst_n,
  adc_wb_if.slave                              wb,
  input  logic [`ADC_LANES-1:0]                overflow,
  input  logic [`ADC_LANES-1:0]                frame_err,
  input  logic [`ADC_LANES-1:0][`ADC_BITS-1:0] fc_pattern,
  output logic                                 twos
);

  adc_capture_pkg::csr_addr_e           addr;
  logic                                 req;
  logic [`WB_DW-1:0]                    rd_data;
  logic [`ADC_LANES-1:0]                ferr_q1;
  logic [`ADC_LANES-1:0]                ferr_q2;
  logic [`ADC_LANES-1:0][`ADC_BITS-1:0] pat_q1;
  logic [`ADC_LANES-1:0][`ADC_BITS-1:0] pat_q2;

  assign addr = adc_capture_pkg::csr_addr_e'(wb.adr);

  // New request only while ack is low.
  assign req = wb.cyc & wb.stb & ~wb.ack;

  always_comb begin
    rd_data = '0;
    case (addr)
      adc_capture_pkg::CTRL:    rd_data[0] = twos;
      adc_capture_pkg::STATUS:  rd_data[2*`ADC_LANES-1:0] = {ferr_q2, overflow};
      adc_capture_pkg::FC_PAT0: rd_data[`ADC_BITS-1:0] = pat_q2[0];
      adc_capture_pkg::FC_PAT1: rd_data[`ADC_BITS-1:0] = pat_q2[1];
      adc_capture_pkg::FC_PAT2: rd_data[`ADC_BITS-1:0] = pat_q2[2];
      adc_capture_pkg::FC_PAT3: rd_data[`ADC_BITS-1:0] = pat_q2[3];
      default:                  rd_data = '0;
    endcase
  end

  // Quasi-static pattern bits cross through two flops.
  always_ff @(posedge clk) begin
    pat_q1 <= fc_pattern;
    pat_q2 <= pat_q1;
    if (req) begin
      wb.dat_r <= rd_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb.ack  <= 1'b0;
      twos    <= 1'b0;
      ferr_q1 <= '0;
      ferr_q2 <= '0;
    end else begin
      wb.ack  <= req;
      ferr_q1 <= frame_err;
      ferr_q2 <= ferr_q1;
      if (req && wb.we && addr == adc_capture_pkg::CTRL) begin
        twos <= wb.dat_w[0];
      end
    end
  end

  // A classic cycle acks each request once while cyc stays high.
  a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
    wb.ack |=> !wb.ack);

endmodule

// ==== design/adc_deserialise.sv ====
`timescale 1ns/1ns
`include "adc_capture_defs.svh"

module adc_deserialise (
  input  logic                     clk,
  input  logic                     rst_n,
  adc_lane_if.mon                  lane,
  output adc_capture_pkg::sample_t word,
  output logic                     word_vld,
  output logic [`ADC_BITS-1:0]     fc_pattern,
  output logic                     frame_err
);

  localparam int FRAME_CYC = `ADC_BITS / 2;
  localparam int CW = $clog2(FRAME_CYC + 2);

  adc_capture_pkg::deser_state_e state;
  logic [CW-1:0]        cnt;
  logic                 fc_q;
  logic                 boundary;
  logic                 good_frame;
  logic [`ADC_BITS-1:0] data_sr;
  logic [`ADC_BITS-1:0] fc_sr;

  // A frame starts where the frame clock goes high on the rising edge.
  assign boundary = lane.fc_rise & ~fc_q;
  assign good_frame = boundary && (state == adc_capture_pkg::TRACK) &&
                      (cnt == CW'(FRAME_CYC));

  // Each cycle shifts in the rise bit ahead of the fall bit so the MSB leads.
  always_ff @(posedge clk) begin
    data_sr <= {data_sr[`ADC_BITS-3:0], lane.rise, lane.fall};
    fc_sr   <= {fc_sr[`ADC_BITS-3:0], lane.fc_rise, lane.fc_fall};
    if (good_frame) begin
      word <= data_sr;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= adc_capture_pkg::SEEK;
      cnt        <= '0;
      fc_q       <= 1'b0;
      word_vld   <= 1'b0;
      fc_pattern <= '0;
      frame_err  <= 1'b0;
    end else begin
      fc_q     <= lane.fc_rise;
      word_vld <= 1'b0;
      if (boundary) begin
        // Boundary cycle counts as the first cycle of the new frame.
        cnt   <= CW'(1);
        state <= adc_capture_pkg::TRACK;
        if (good_frame) begin
          word_vld   <= 1'b1;
          fc_pattern <= fc_sr;
        end else if (state == adc_capture_pkg::TRACK) begin
          frame_err <= 1'b1;
        end
      end else if (cnt != '1) begin
        // Saturate so a stalled frame clock cannot alias to a good length.
        cnt <= cnt + 1'b1;
      end
    end
  end

  // Each word closes a frame whose opening boundary is six cycles older.
  a_no_word_in_seek: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(word_vld) |-> $past(boundary, FRAME_CYC + 1));

endmodule

// ==== design/adc_lane_if.sv ====
`timescale 1ns/1ns

interface adc_lane_if;

  // Data and frame clock as sampled on both edges of adc_clk0.
  logic rise;
  logic fall;
  logic fc_rise;
  logic fc_fall;

  modport drv (output rise, output fall, output fc_rise, output fc_fall);
  modport mon (input rise, input fall, input fc_rise, input fc_fall);

endinterface

// ==== design/adc_retime.sv ====
`timescale 1ns/1ns
`include "adc_capture_defs.svh"

module adc_retime (
  input  logic                     wr_clk,
  input  logic                     rd_clk,
  input  logic                     rst_n,
  input  adc_capture_pkg::sample_t din,
  input  logic                     dvld,
  input  logic                     rd_en,
  output adc_capture_pkg::sample_t dout,
  output logic                     empty,
  output logic                     overflow
);

  localparam int AW = `ADC_FIFO_AW;

  adc_capture_pkg::sample_t mem [2**AW];

  logic [AW:0] wr_bin;
  logic [AW:0] wr_bin_nxt;
  logic [AW:0] wr_gray;
  logic [AW:0] rd_bin;
  logic [AW:0] rd_bin_nxt;
  logic [AW:0] rd_gray;
  logic [AW:0] rg_q1;
  logic [AW:0] rg_q2;
  logic [AW:0] wg_q1;
  logic [AW:0] wg_q2;
  logic        full;
  logic        ovf_wr;
  logic        ovf_q1;

  assign wr_bin_nxt = wr_bin + 1'b1;
  assign rd_bin_nxt = rd_bin + 1'b1;

  // Full when the pointers differ only in the two top Gray bits.
  assign full  = (wr_gray == {~rg_q2[AW:AW-1], rg_q2[AW-2:0]});
  assign empty = (rd_gray == wg_q2);

  // First word falls through.
  assign dout = mem[rd_bin[AW-1:0]];

  always_ff @(posedge wr_clk) begin
    if (dvld && !full) begin
      mem[wr_bin[AW-1:0]] <= din;
    end
  end

  always_ff @(posedge wr_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_bin  <= '0;
      wr_gray <= '0;
      rg_q1   <= '0;
      rg_q2   <= '0;
      ovf_wr  <= 1'b0;
    end else begin
      rg_q1 <= rd_gray;
      rg_q2 <= rg_q1;
      if (dvld) begin
        if (full) begin
          ovf_wr <= 1'b1;
        end else begin
          wr_bin  <= wr_bin_nxt;
          wr_gray <= wr_bin_nxt ^ (wr_bin_nxt >> 1);
        end
      end
    end
  end

  always_ff @(posedge rd_clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_bin   <= '0;
      rd_gray  <= '0;
      wg_q1    <= '0;
      wg_q2    <= '0;
      ovf_q1   <= 1'b0;
      overflow <= 1'b0;
    end else begin
      wg_q1    <= wr_gray;
      wg_q2    <= wg_q1;
      ovf_q1   <= ovf_wr;
      overflow <= ovf_q1;
      if (rd_en && !empty) begin
        rd_bin  <= rd_bin_nxt;
        rd_gray <= rd_bin_nxt ^ (rd_bin_nxt >> 1);
      end
    end
  end

  // The aligner must only read a lane that holds a word.
  a_no_read_empty: assert property (@(posedge rd_clk) disable iff (!rst_n)
    rd_en |-> !empty);

endmodule

// ==== design/adc_wb_if.sv ====
`timescale 1ns/1ns
`include "adc_capture_defs.svh"

interface adc_wb_if;

  logic             cyc;
  logic             stb;
  logic             we;
  logic [`WB_AW-1:0] adr;
  logic [`WB_DW-1:0] dat_w;
  logic [`WB_DW-1:0] dat_r;
  logic             ack;

  modport master (output cyc, output stb, output we, output adr, output dat_w,
                  input dat_r, input ack);
  modport slave  (input cyc, input stb, input we, input adr, input dat_w,
                  output dat_r, output ack);

endinterface

// ==== verification/adc_capture_tb.sv ====
`timescale 1ns/1ns
`include "adc_capture_defs.svh"

module adc_capture_tb;

  // Frame length and delay hold one byte per lane, lane 3 first.
  typedef struct packed {
    logic [3:0][7:0] flen;
    logic [3:0][7:0] delay;
    int              twos;
    int              nsamp;
    int              check;
    int              status;
  } row_t;

  localparam int NROWS = 6;

  // flen, delay in frames, twos, samples, data checked, expected STATUS.
  localparam row_t ROWS [NROWS] = '{
    '{{8'd6, 8'd6, 8'd6, 8'd6}, {8'd0, 8'd0, 8'd0, 8'd0},  0, 10, 1, 32'h00},
    '{{8'd6, 8'd6, 8'd6, 8'd6}, {8'd0, 8'd0, 8'd0, 8'd0},  1, 10, 1, 32'h00},
    '{{8'd6, 8'd6, 8'd6, 8'd6}, {8'd2, 8'd0, 8'd0, 8'd0},  0, 10, 1, 32'h00},
    '{{8'd6, 8'd6, 8'd6, 8'd6}, {8'd0, 8'd0, 8'd12, 8'd0}, 0, 16, 0, 32'h0d},
    '{{8'd6, 8'd5, 8'd6, 8'd6}, {8'd0, 8'd0, 8'd0, 8'd0},  0, 10, 1, 32'h40},
    '{{8'd6, 8'd6, 8'd6, 8'd6}, {8'd0, 8'd2, 8'd0, 8'd1},  1, 8,  1, 32'h00}
  };

  logic                                 adc_clk0 = 1'b0;
  logic                                 fab_clk = 1'b0;
  logic                                 rst_n;
  logic [`ADC_LANES-1:0]                rise;
  logic [`ADC_LANES-1:0]                fall;
  logic [`ADC_LANES-1:0]                fc_rise;
  logic [`ADC_LANES-1:0]                fc_fall;
  logic                                 wb_cyc;
  logic                                 wb_stb;
  logic                                 wb_we;
  logic [`WB_AW-1:0]                    wb_adr;
  logic [`WB_DW-1:0]                    wb_dat_w;
  logic [`WB_DW-1:0]                    wb_dat_r;
  logic                                 wb_ack;
  logic [`ADC_LANES-1:0][`ADC_BITS-1:0] sample_data;
  logic                                 sample_vld;

  logic [3:0]           stim_q [`ADC_LANES][$];
  logic [`ADC_BITS-1:0] exp_q [`ADC_LANES][$];
  logic [31:0]          lfsr_state;
  logic                 check_data;
  int                   cycles;
  int                   cycle_limit;

  adc_capture_top dut_i (.*);

  always #4 adc_clk0 = ~adc_clk0;

  // Rising edges trail adc_clk0 by 3 ns.
  always begin
    #3 fab_clk = 1'b0;
    #4 fab_clk = 1'b1;
    #1;
  end

  always @(posedge adc_clk0) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("TEST FAIL");
      $fatal(1, "Timeout, run still busy after %0d adc_clk0 cycles", cycles);
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  function automatic int total_frames();
    int sum;
    int dmax;
    sum = 0;
    for (int r = 0; r < NROWS; r++) begin
      dmax = 0;
      for (int i = 0; i < `ADC_LANES; i++) begin
        if (int'(ROWS[r].delay[i]) > dmax) dmax = int'(ROWS[r].delay[i]);
      end
      sum += ROWS[r].nsamp + 2 + dmax;
    end
    return sum;
  endfunction

  function automatic bit streams_pending();
    bit busy;
    busy = 1'b0;
    for (int i = 0; i < `ADC_LANES; i++) busy |= (stim_q[i].size() != 0);
    return busy;
  endfunction

  function automatic bit expected_pending();
    bit busy;
    busy = 1'b0;
    for (int i = 0; i < `ADC_LANES; i++) busy |= (exp_q[i].size() != 0);
    return busy;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      $display("** Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, want);
      $display("TEST FAIL");
      $fatal(1, "Value mismatch on %s", name);
    end
  endtask

  task automatic draw_sample(output logic [`ADC_BITS-1:0] val);
    val = '0;
    for (int b = 0; b < `ADC_BITS; b++) begin
      val = {val[`ADC_BITS-2:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // Queues one lane's cycles and the expected word of each good frame.
  task automatic build_lane(input int lane, input row_t r);
    int                   nf;
    int                   short_idx;
    int                   len;
    logic                 fc;
    logic [`ADC_BITS-1:0] val;
    short_idx = r.nsamp / 2;
    nf = r.nsamp + 1 + ((int'(r.flen[lane]) != 6) ? 1 : 0);
    repeat (int'(r.delay[lane]) * 6) stim_q[lane].push_back(4'b0000);
    for (int f = 0; f < nf; f++) begin
      len = (f == short_idx) ? int'(r.flen[lane]) : 6;
      draw_sample(val);
      for (int c = 0; c < len; c++) begin
        fc = (c < 3);
        stim_q[lane].push_back({val[11-2*c], val[10-2*c], fc, fc});
      end
      // A word leaves only at a following boundary after six cycles.
      if (len == 6 && f < nf - 1) begin
        exp_q[lane].push_back(val ^ ((r.twos != 0) ? 12'h800 : 12'h000));
      end
    end
  endtask

  task automatic drive_streams();
    logic [3:0] bits;
    while (streams_pending()) begin
      @(posedge adc_clk0);
      #1;
      for (int i = 0; i < `ADC_LANES; i++) begin
        bits = (stim_q[i].size() != 0) ? stim_q[i].pop_front() : 4'b0000;
        rise[i]    = bits[3];
        fall[i]    = bits[2];
        fc_rise[i] = bits[1];
        fc_fall[i] = bits[0];
      end
    end
    @(posedge adc_clk0);
    #1;
    {rise, fall, fc_rise, fc_fall} = '0;
  endtask

  task automatic wait_ack();
    do begin
      @(posedge fab_clk);
      #1;
    end while (!wb_ack);
  endtask

  task automatic wb_write(input logic [`WB_AW-1:0] adr, input logic [`WB_DW-1:0] data);
    @(posedge fab_clk);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = data;
    wait_ack();
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_read(input logic [`WB_AW-1:0] adr, output logic [`WB_DW-1:0] data);
    @(posedge fab_clk);
    #1;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    wait_ack();
    data   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (3) @(posedge adc_clk0);
    #1 rst_n = 1'b1;
  endtask

  task automatic compare_set();
    for (int i = 0; i < `ADC_LANES; i++) begin
      if (exp_q[i].size() == 0) begin
        $display("TEST FAIL");
        $fatal(1, "Sample set arrived while nothing was expected on lane %0d", i);
      end else begin
        check_value($sformatf("sample_data[%0d]", i), 32'(sample_data[i]),
                    32'(exp_q[i].pop_front()));
      end
    end
  endtask

  always @(negedge fab_clk) begin
    if (check_data && sample_vld) compare_set();
  end

  task automatic run_row(input row_t r);
    logic [`WB_DW-1:0] data;
    check_data = 1'b0;
    apply_reset();
    for (int i = 0; i < `ADC_LANES; i++) begin
      stim_q[i].delete();
      exp_q[i].delete();
    end
    wb_write(adc_capture_pkg::CTRL, r.twos);
    wb_read(adc_capture_pkg::CTRL, data);
    check_value("CTRL", data, r.twos);
    for (int i = 0; i < `ADC_LANES; i++) build_lane(i, r);
    check_data = (r.check != 0);
    drive_streams();
    if (r.check != 0) begin
      while (expected_pending()) @(posedge fab_clk);
    end
    wb_read(adc_capture_pkg::STATUS, data);
    check_value("STATUS", data, r.status);
    for (int i = 0; i < `ADC_LANES; i++) begin
      wb_read(4'(2 + i), data);
      check_value($sformatf("FC_PAT%0d", i), data, 32'h0000_0fc0);
    end
  endtask

  initial begin
    rst_n       = 1'b0;
    {rise, fall, fc_rise, fc_fall} = '0;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = '0;
    wb_dat_w    = '0;
    check_data  = 1'b0;
    lfsr_state  = 32'hefce_135e;
    cycle_limit = 20 * total_frames() + 200;
    for (int r = 0; r < NROWS; r++) run_row(ROWS[r]);
    $display("TEST PASS");
    $finish;
  end

endmodule
